/* all.f */
logic/request_pkg.sv
logic/request_if.sv
logic/request_ingress.sv
logic/request_fifo.sv
logic/request_dispatch.sv
logic/request_distributor.sv
test/request_checker.sv
test/tb_request_distributor.sv

/* logic/request_dispatch.sv */
// Request dispatch stage

`timescale 1ns/1ps

module request_dispatch
  import request_pkg::*;
(
  input  logic    ap_clk,
  input  logic    areset_control,
  input  route_t  ready,
  request_if.sink queue_head,
  output route_t  out_valid,
  output data_t   out_data
);

  route_t ready_reg;
  route_t ready_masked;
  logic   targets_ready;
  logic   pop;

  // ------------------------------------------------------------------
  // Requestor readiness
  // ------------------------------------------------------------------

  // Pop decision uses last cycle's levels
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      ready_reg <= '0;
    end else begin
      ready_reg <= ready;
    end
  end

  // ------------------------------------------------------------------
  // Pop decision
  // ------------------------------------------------------------------

  // Only the requestors named by the head count
  assign ready_masked  = ready_reg & queue_head.route;
  assign targets_ready = (ready_masked == queue_head.route);

  // Head waits until all its targets are ready
  assign pop = queue_head.valid & targets_ready;

  assign queue_head.ready = pop;

  // ------------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------------

  // One-cycle pulse on each targeted requestor
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      out_valid <= '0;
    end else if (pop) begin
      out_valid <= queue_head.route;
    end else begin
      out_valid <= '0;
    end
  end

  // Data word shared by all outputs
  always_ff @(posedge ap_clk) begin
    if (pop) begin
      out_data <= queue_head.data;
    end
  end

endmodule : request_dispatch

/* logic/request_distributor.sv */
// One-to-many request distributor

`timescale 1ns/1ps

module request_distributor
  import request_pkg::*;
#(
  parameter int FIFO_DEPTH = FIFO_DEPTH_DEFAULT
) (
  input  logic   ap_clk,
  input  logic   areset_control,
  input  logic   in_valid,
  input  route_t in_route,
  input  data_t  in_data,
  input  route_t ready,
  output logic   in_full,
  output route_t out_valid,
  output data_t  out_data
);

  // ------------------------------------------------------------------
  // Stage links
  // ------------------------------------------------------------------
  request_if ingress_q ();
  request_if queue_head ();

  // ------------------------------------------------------------------
  // Pipeline
  // ------------------------------------------------------------------
  request_ingress request_ingress_inst (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .in_valid       (in_valid),
    .in_route       (in_route),
    .in_data        (in_data),
    .ingress_q      (ingress_q.source)
  );

  request_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) request_fifo_inst (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .ingress_q      (ingress_q.sink),
    .queue_head     (queue_head.source),
    .in_full        (in_full)
  );

  request_dispatch request_dispatch_inst (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .ready          (ready),
    .queue_head     (queue_head.sink),
    .out_valid      (out_valid),
    .out_data       (out_data)
  );

endmodule : request_distributor

/* logic/request_fifo.sv */
// Request queue

`timescale 1ns/1ps

module request_fifo
  import request_pkg::*;
#(
  parameter int FIFO_DEPTH = FIFO_DEPTH_DEFAULT
) (
  input  logic      ap_clk,
  input  logic      areset_control,
  request_if.sink   ingress_q,
  request_if.source queue_head,
  output logic      in_full
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  request_t   mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // ------------------------------------------------------------------
  // Write and read strobes
  // ------------------------------------------------------------------
  assign push = ingress_q.valid & ingress_q.ready;
  assign pop  = queue_head.valid & queue_head.ready;

  // Room for one more entry
  assign ingress_q.ready = (count < CNT_W'(FIFO_DEPTH));

  // Two slots kept back for the packet in the ingress register
  assign in_full = (count >= CNT_W'(FIFO_DEPTH - 2));

  // ------------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (push) begin
      mem[wr_ptr] <= '{route: ingress_q.route, data: ingress_q.data};
    end
  end

  // Pointers wrap at FIFO_DEPTH
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      count <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ------------------------------------------------------------------
  // First word falls through to the head
  // ------------------------------------------------------------------
  assign queue_head.valid = (count != '0);
  assign queue_head.route = mem[rd_ptr].route;
  assign queue_head.data  = mem[rd_ptr].data;

endmodule : request_fifo

/* logic/request_if.sv */
// Request stream interface

`timescale 1ns/1ps

interface request_if
  import request_pkg::*;
();

  // Packet moves on an edge with valid and ready both high
  logic   valid;
  route_t route;
  data_t  data;
  logic   ready;

  // Upstream side
  modport source (
    output valid,
    output route,
    output data,
    input  ready
  );

  // Downstream side
  modport sink (
    input  valid,
    input  route,
    input  data,
    output ready
  );

endinterface : request_if

/* logic/request_ingress.sv */
// Request ingress stage

`timescale 1ns/1ps

module request_ingress
  import request_pkg::*;
(
  input  logic      ap_clk,
  input  logic      areset_control,
  input  logic      in_valid,
  input  route_t    in_route,
  input  data_t     in_data,
  request_if.source ingress_q
);

  logic   valid_reg;
  route_t route_reg;
  data_t  data_reg;
  logic   load;

  // ------------------------------------------------------------------
  // Input register
  // ------------------------------------------------------------------

  // Hold the packet while the queue refuses it
  assign load = ~ingress_q.valid | ingress_q.ready;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      valid_reg <= 1'b0;
    end else if (load) begin
      valid_reg <= in_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (load) begin
      route_reg <= in_route;
      data_reg  <= in_data;
    end
  end

  // ------------------------------------------------------------------
  // Stream towards the queue
  // ------------------------------------------------------------------

  // Empty routes never reach the queue
  assign ingress_q.valid = valid_reg & (|route_reg);
  assign ingress_q.route = route_reg;
  assign ingress_q.data  = data_reg;

endmodule : request_ingress

/* logic/request_pkg.sv */
// Request distributor definitions

package request_pkg;

  // ------------------------------------------------------------------
  // Sizing
  // ------------------------------------------------------------------
  localparam int NUM_REQUESTORS     = 4;
  localparam int DATA_WIDTH         = 32;
  localparam int FIFO_DEPTH_DEFAULT = 16;

  // ------------------------------------------------------------------
  // Packet types
  // ------------------------------------------------------------------

  // Bit i selects requestor i
  typedef logic [NUM_REQUESTORS-1:0] route_t;

  typedef logic [DATA_WIDTH-1:0] data_t;

  // Queue entry
  typedef struct packed {
    route_t route;
    data_t  data;
  } request_t;

endpackage : request_pkg

/* run.sh */
#!/bin/sh
# Compile and run the request distributor testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f all.f --top-module tb_request_distributor -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "All tests passed!" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

/* test/request_checker.sv */
// Request distributor output checker

`timescale 1ns/1ps

module request_checker
  import request_pkg::*;
(
  input logic   ap_clk,
  input logic   areset_control,
  input route_t ready,
  input logic   in_full,
  input route_t out_valid,
  input data_t  out_data
);

  // Predicted packets per requestor in arrival order
  string  exp_name  [NUM_REQUESTORS][$];
  route_t exp_route [NUM_REQUESTORS][$];
  data_t  exp_data  [NUM_REQUESTORS][$];
  int     exp_seq   [NUM_REQUESTORS][$];

  int     next_seq    = 0;
  int     last_seq    = 0;
  int     error_count = 0;
  int     delivered   = 0;
  logic   in_reset_q  = 1'b0;
  logic   full_seen   = 1'b0;
  route_t ready_d1    = '0;
  route_t ready_d2    = '0;

  // ------------------------------------------------------------------
  // Prediction
  // ------------------------------------------------------------------
  task automatic expect_packet(input string name, input route_t route, input data_t data);
    for (int i = 0; i < NUM_REQUESTORS; i++) begin
      if (route[i]) begin
        exp_name[i].push_back(name);
        exp_route[i].push_back(route);
        exp_data[i].push_back(data);
        exp_seq[i].push_back(next_seq);
      end
    end
    next_seq++;
  endtask

  function automatic int pending();
    int total;
    total = 0;
    for (int i = 0; i < NUM_REQUESTORS; i++) begin
      total += exp_data[i].size();
    end
    return total;
  endfunction

  // Leftover packets and missing back-pressure
  function automatic int drain_errors();
    int errors;
    errors = 0;
    for (int i = 0; i < NUM_REQUESTORS; i++) begin
      if (exp_data[i].size() != 0) begin
        $display("Requestor %0d never received %0d expected packets", i, exp_data[i].size());
        errors++;
      end
    end
    if (!full_seen) begin
      $display("in_full never rose during the back-pressure rows");
      errors++;
    end
    return errors;
  endfunction

  // ------------------------------------------------------------------
  // Output monitor
  // ------------------------------------------------------------------
  always @(posedge ap_clk) begin
    string  name;
    route_t route;
    data_t  data;
    int     seq;
    int     seq_max;
    seq_max = last_seq;
    if (areset_control) begin
      in_reset_q <= 1'b1;
    end else begin
      // First cycle out of reset
      if (in_reset_q && (out_valid !== '0 || in_full !== 1'b0)) begin
        $display("Outputs not idle after reset: out_valid %b in_full %b", out_valid, in_full);
        error_count++;
      end
      in_reset_q <= 1'b0;
      if (in_full === 1'b1) begin
        full_seen <= 1'b1;
      end
      for (int i = 0; i < NUM_REQUESTORS; i++) begin
        if (out_valid[i] === 1'b1) begin
          if (exp_data[i].size() == 0) begin
            $display("Unexpected pulse on requestor %0d with data %h", i, out_data);
            error_count++;
          end else begin
            name  = exp_name[i].pop_front();
            route = exp_route[i].pop_front();
            data  = exp_data[i].pop_front();
            seq   = exp_seq[i].pop_front();
            delivered++;
            if (out_data !== data) begin
              $display("FAIL %s requestor %0d: expected data %h, actual %h",
                       name, i, data, out_data);
              error_count++;
            end
            // All targets of a packet pulse together
            if (out_valid !== route) begin
              $display("FAIL %s requestor %0d: expected out_valid %b, actual %b",
                       name, i, route, out_valid);
              error_count++;
            end
            // Pop edge used readiness from two edges back
            if (ready_d2[i] !== 1'b1) begin
              $display("Requestor %0d got packet %s while its ready was low", i, name);
              error_count++;
            end
            if (seq < last_seq) begin
              $display("Packet %s on requestor %0d overtook an earlier packet", name, i);
              error_count++;
            end
            if (seq > seq_max) begin
              seq_max = seq;
            end
          end
        end
      end
      last_seq = seq_max;
    end
    ready_d1 <= ready;
    ready_d2 <= ready_d1;
  end

endmodule : request_checker

/* test/tb_request_distributor.sv */
// Request distributor testbench

`timescale 1ns/1ps

module tb_request_distributor
  import request_pkg::*;
();

  localparam int CLK_PERIOD = 8;
  localparam int DEPTH      = FIFO_DEPTH_DEFAULT;

  logic   ap_clk;
  logic   areset_control;
  logic   in_valid;
  route_t in_route;
  data_t  in_data;
  route_t ready;
  logic   in_full;
  route_t out_valid;
  data_t  out_data;

  // Stimulus table with one entry per row in each queue
  string  row_name  [$];
  route_t row_route [$];
  data_t  row_data  [$];
  route_t row_ready [$];
  logic   row_sync  [$];
  int     row_count = 0;

  request_distributor #(
    .FIFO_DEPTH (DEPTH)
  ) request_distributor_inst (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .in_valid       (in_valid),
    .in_route       (in_route),
    .in_data        (in_data),
    .ready          (ready),
    .in_full        (in_full),
    .out_valid      (out_valid),
    .out_data       (out_data)
  );

  request_checker checker_inst (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .ready          (ready),
    .in_full        (in_full),
    .out_valid      (out_valid),
    .out_data       (out_data)
  );

  initial begin
    ap_clk = 1'b0;
    forever #(CLK_PERIOD / 2) ap_clk = ~ap_clk;
  end

  // ------------------------------------------------------------------
  // Stimulus table
  // ------------------------------------------------------------------
  task automatic add_row(input string name, input route_t route, input data_t data,
                         input route_t rdy, input logic sync);
    row_name.push_back(name);
    row_route.push_back(route);
    row_data.push_back(data);
    row_ready.push_back(rdy);
    row_sync.push_back(sync);
  endtask

  task automatic build_table();
    add_row("unicast_r0", 4'b0001, 32'h1000_0000, 4'b1111, 1'b0);
    add_row("unicast_r1", 4'b0010, 32'h1000_0001, 4'b1111, 1'b0);
    add_row("unicast_r2", 4'b0100, 32'h1000_0002, 4'b1111, 1'b0);
    add_row("unicast_r3", 4'b1000, 32'h1000_0003, 4'b1111, 1'b0);
    add_row("multicast_pair", 4'b0011, 32'h2000_0000, 4'b1111, 1'b0);
    add_row("multicast_odd", 4'b1010, 32'h2000_0001, 4'b1111, 1'b0);
    add_row("multicast_all", 4'b1111, 32'h2000_0002, 4'b1111, 1'b0);
    add_row("empty_a", 4'b0000, 32'h3000_0000, 4'b1111, 1'b0);
    add_row("empty_b", 4'b0000, 32'h3000_0001, 4'b1111, 1'b0);
    add_row("after_empty", 4'b0100, 32'h3000_0002, 4'b1111, 1'b0);
    // Requestor 2 held back while later packets wait behind it
    add_row("stall_hold", 4'b0100, 32'h4000_0000, 4'b1011, 1'b0);
    add_row("stall_r0", 4'b0001, 32'h4000_0001, 4'b1011, 1'b0);
    add_row("stall_r3", 4'b1000, 32'h4000_0002, 4'b1011, 1'b0);
    add_row("stall_release", 4'b0110, 32'h4000_0003, 4'b1111, 1'b1);
    // Fill the queue up to the in_full level with nobody ready
    for (int i = 0; i < DEPTH - 2; i++) begin
      add_row($sformatf("backpressure_%0d", i), route_t'(i % 15 + 1),
              data_t'(32'h5000_0000 + i), 4'b0000, 1'b0);
    end
    add_row("backpressure_release", 4'b1111, 32'h5000_00ff, 4'b1111, 1'b1);
  endtask

  // Called on a falling edge
  task automatic send_row(input int idx);
    int gap;
    ready = row_ready[idx];
    while (in_full) @(negedge ap_clk);
    in_valid = 1'b1;
    in_route = row_route[idx];
    in_data  = row_data[idx];
    checker_inst.expect_packet(row_name[idx], row_route[idx], row_data[idx]);
    @(negedge ap_clk);
    in_valid = 1'b0;
    gap = $urandom % 3;
    repeat (gap) @(negedge ap_clk);
    if (row_sync[idx]) begin
      while (checker_inst.pending() != 0) @(negedge ap_clk);
    end
  endtask

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------
  initial begin
    int total_errors;
    void'($urandom(36));
    areset_control = 1'b1;
    in_valid       = 1'b0;
    in_route       = '0;
    in_data        = '0;
    ready          = '0;
    build_table();
    row_count = row_name.size();
    repeat (4) @(posedge ap_clk);
    @(negedge ap_clk);
    areset_control = 1'b0;
    // Quiet period before the first request
    repeat (4) @(negedge ap_clk);
    for (int i = 0; i < row_count; i++) begin
      send_row(i);
    end
    while (checker_inst.pending() != 0) @(negedge ap_clk);
    // Tail to catch stray pulses
    repeat (8) @(negedge ap_clk);
    total_errors = checker_inst.error_count + checker_inst.drain_errors();
    $display("Summary: %0d deliveries checked, %0d errors", checker_inst.delivered,
             total_errors);
    if (total_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (row_count > 0);
    repeat (40 * row_count + 200) @(posedge ap_clk);
    $display("Timeout: run did not finish within %0d cycles", 40 * row_count + 200);
    $display("Test failures found");
    $finish;
  end

endmodule : tb_request_distributor
